// ==== source/fetch_consts.svh ====
// shared sizing macros: address width, ram depth, queue depth, boot address
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// memory geometry
//////////////////////////////////////////////////////////////////////

// byte address width of the core
`define FETCH_ADDR_W 32

// instruction ram depth in 32-bit words
`define FETCH_RAM_WORDS 256

//////////////////////////////////////////////////////////////////////
// fetch path
//////////////////////////////////////////////////////////////////////

// prefetch queue entries
`define FETCH_QUEUE_DEPTH 2

// pc and first fetch address after reset
`define FETCH_BOOT_ADDR 32'h0000_0000

`endif

// ==== source/mem_pkg.sv ====
// memory-side types: ram word, word index, arbiter port owner
`default_nettype none

`include "fetch_consts.svh"

package mem_pkg;

  // one ram word, also one raw fetch word
  typedef logic [31:0] mem_word_t;

  // word index into the instruction ram
  typedef logic [$clog2(`FETCH_RAM_WORDS)-1:0] mem_index_t;

  // which peer held the ram port in a given cycle
  typedef enum logic [0:0] {
    OWNER_LOADER   = 1'b0,
    OWNER_PREFETCH = 1'b1
  } arb_owner_e;

endpackage

`default_nettype wire

// ==== source/fetch_pkg.sv ====
// fetch-side types: aligner states, stored halfword, program counter
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

  // aligner fsm states
  // aligned32 and misaligned16 start at the low half of the head word
  // aligned16 and misaligned32 start in the stored half
  // branch_misaligned starts in the upper half of the head word
  typedef enum logic [2:0] {
    ALIGNED32         = 3'd0,
    ALIGNED16         = 3'd1,
    MISALIGNED32      = 3'd2,
    MISALIGNED16      = 3'd3,
    BRANCH_MISALIGNED = 3'd4
  } align_state_e;

  // upper halfword kept from the last consumed word
  typedef logic [15:0] half_t;

  // byte address of an instruction
  typedef logic [`FETCH_ADDR_W-1:0] pc_t;

endpackage

`default_nettype wire

// ==== source/instr_ram.sv ====
// single-port instruction memory with synchronous write and registered read
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module instr_ram
  import mem_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       en_i,
  input  wire logic       we_i,
  input  wire mem_index_t index_i,
  input  wire mem_word_t  wdata_i,
  output mem_word_t       rdata_o
);

  // word storage, contents come from the loader port
  mem_word_t mem_q [`FETCH_RAM_WORDS];

  //////////////////////////////////////////////////////////////////////
  // port access
  //////////////////////////////////////////////////////////////////////

  // one access per cycle
  // write updates the array, read lands in rdata_o on the next cycle
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[index_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[index_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/ram_arbiter.sv ====
// fixed-priority arbiter for the instruction ram: loader writes before prefetch reads
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter
  import mem_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  // loader port, write strobe
  input  wire logic       load_we_i,
  input  wire mem_index_t load_index_i,
  input  wire mem_word_t  load_data_i,
  // prefetch port, read request level
  input  wire logic       pf_req_i,
  input  wire mem_index_t pf_index_i,
  output logic            pf_gnt_o,
  output logic            pf_rvalid_o,
  // ram side
  output logic            ram_en_o,
  output logic            ram_we_o,
  output mem_index_t      ram_index_o,
  output mem_word_t       ram_wdata_o
);

  arb_owner_e owner_n;
  arb_owner_e rd_owner_q;
  logic       rd_pend_q;

  //////////////////////////////////////////////////////////////////////
  // grant and port mux
  //////////////////////////////////////////////////////////////////////

  // loader always wins, prefetch just retries next cycle
  assign owner_n  = load_we_i ? OWNER_LOADER : OWNER_PREFETCH;
  assign pf_gnt_o = pf_req_i & ~load_we_i;

  assign ram_en_o    = load_we_i | pf_req_i;
  assign ram_we_o    = load_we_i;
  assign ram_index_o = load_we_i ? load_index_i : pf_index_i;
  // only the loader ever writes
  assign ram_wdata_o = load_data_i;

  //////////////////////////////////////////////////////////////////////
  // read return tracking
  //////////////////////////////////////////////////////////////////////

  // remember who issued the read so data returns to its owner only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_owner_q <= OWNER_LOADER;
      rd_pend_q  <= 1'b0;
    end else begin
      rd_owner_q <= owner_n;
      rd_pend_q  <= ram_en_o & ~ram_we_o;
    end
  end

  // one-cycle pulse with the ram read latency
  assign pf_rvalid_o = rd_pend_q & (rd_owner_q == OWNER_PREFETCH);

endmodule

`default_nettype wire

// ==== source/prefetch_buffer.sv ====
// sequential word prefetcher with a small circular queue and branch flush
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module prefetch_buffer
  import mem_pkg::*;
  import fetch_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       fetch_en_i,
  // ram arbiter side
  input  wire logic       gnt_i,
  input  wire logic       rvalid_i,
  input  wire mem_word_t  rdata_i,
  output logic            req_o,
  output mem_index_t      index_o,
  // aligner side
  input  wire logic       word_pop_i,
  output logic            fetch_valid_o,
  output mem_word_t       mem_content_o,
  // redirect
  input  wire logic       branch_i,
  input  wire pc_t        branch_addr_i
);

  localparam int unsigned DEPTH = `FETCH_QUEUE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam int unsigned IDX_W = $bits(mem_index_t);
  localparam mem_index_t BOOT_INDEX = mem_index_t'(`FETCH_BOOT_ADDR >> 2);

  mem_word_t        queue_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] inflight_q;
  mem_index_t       fetch_idx_q;
  logic             push;
  logic             pop;
  logic [CNT_W:0]   occupancy;

  // circular pointer step
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  // a response landing in the branch cycle belongs to the old stream
  assign push = rvalid_i & ~branch_i;
  assign pop  = word_pop_i & (count_q != '0);

  // queued words plus reads still on the way, minus the word leaving now
  assign occupancy = {1'b0, count_q} + {1'b0, inflight_q} - (CNT_W + 1)'(pop);

  // no new read in a branch cycle
  assign req_o   = fetch_en_i & ~branch_i &
                   (occupancy < (CNT_W + 1)'(DEPTH));
  assign index_o = fetch_idx_q;

  //////////////////////////////////////////////////////////////////////
  // control state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_idx_q <= BOOT_INDEX;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      inflight_q  <= '0;
    end else begin
      inflight_q <= inflight_q + CNT_W'(gnt_i) - CNT_W'(rvalid_i);
      if (branch_i) begin
        // flush and restart at the word holding the target
        fetch_idx_q <= branch_addr_i[IDX_W+1:2];
        wr_ptr_q    <= '0;
        rd_ptr_q    <= '0;
        count_q     <= '0;
      end else begin
        if (gnt_i) begin
          fetch_idx_q <= fetch_idx_q + 1'b1;
        end
        if (push) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
      end
    end
  end

  // queue payload
  always_ff @(posedge clk) begin
    if (push) begin
      queue_q[wr_ptr_q] <= rdata_i;
    end
  end

  assign fetch_valid_o = (count_q != '0);
  assign mem_content_o = queue_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== source/instr_aligner.sv ====
// compressed instruction aligner fsm with program counter tracking
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module instr_aligner
  import mem_pkg::*;
  import fetch_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  // head of the prefetch queue
  input  wire logic       fetch_valid_i,
  input  wire mem_word_t  mem_content_i,
  output logic            word_pop_o,
  // decode stage
  input  wire logic       id_valid_i,
  output mem_word_t       instr_o,
  output logic            instr_valid_o,
  output logic            instr_compress_o,
  output pc_t             pc_o,
  // redirect
  input  wire logic       branch_i,
  input  wire pc_t        branch_addr_i
);

  align_state_e state_q;
  align_state_e state_n;
  half_t        r_instr_q;
  pc_t          pc_q;
  pc_t          pc_n;
  pc_t          pc_plus2;
  pc_t          pc_plus4;
  logic         update_state;
  logic         consume;

  assign pc_o     = pc_q;
  assign pc_plus2 = pc_q + pc_t'(2);
  assign pc_plus4 = pc_q + pc_t'(4);

  //////////////////////////////////////////////////////////////////////
  // state and pc registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGNED32;
      pc_q    <= pc_t'(`FETCH_BOOT_ADDR);
    end else if (update_state) begin
      state_q <= state_n;
      pc_q    <= pc_n;
    end
  end

  // keep the upper half of every word that leaves the queue
  always_ff @(posedge clk) begin
    if (word_pop_o) begin
      r_instr_q <= mem_content_i[31:16];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // next state and instruction mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // defaults: full head word, needs a valid head
    state_n          = state_q;
    pc_n             = pc_q;
    instr_o          = mem_content_i;
    instr_valid_o    = fetch_valid_i;
    instr_compress_o = 1'b0;
    update_state     = 1'b0;
    consume          = 1'b0;

    case (state_q)
      // instruction starts at the low half of the head word
      ALIGNED32, MISALIGNED16: begin
        consume      = 1'b1;
        update_state = fetch_valid_i & id_valid_i;
        if (mem_content_i[1:0] == 2'b11) begin
          state_n = ALIGNED32;
          pc_n    = pc_plus4;
        end else begin
          // upper half is kept for the next one
          state_n          = ALIGNED16;
          pc_n             = pc_plus2;
          instr_o          = {16'b0, mem_content_i[15:0]};
          instr_compress_o = 1'b1;
        end
      end

      // instruction starts in the stored half
      ALIGNED16, MISALIGNED32: begin
        if (r_instr_q[1:0] == 2'b11) begin
          // completed by the low half of the head word
          state_n      = MISALIGNED32;
          pc_n         = pc_plus4;
          instr_o      = {mem_content_i[15:0], r_instr_q};
          consume      = 1'b1;
          update_state = fetch_valid_i & id_valid_i;
        end else begin
          // stored half alone, head word stays in the queue
          state_n          = MISALIGNED16;
          pc_n             = pc_plus2;
          instr_o          = {16'b0, r_instr_q};
          instr_valid_o    = 1'b1;
          instr_compress_o = 1'b1;
          update_state     = id_valid_i;
        end
      end

      // target is the upper half of the head word
      BRANCH_MISALIGNED: begin
        consume = 1'b1;
        if (mem_content_i[17:16] == 2'b11) begin
          // 32-bit at a halfword target, park the half and wait for the next word
          state_n       = MISALIGNED32;
          instr_valid_o = 1'b0;
          update_state  = fetch_valid_i;
        end else begin
          state_n          = ALIGNED32;
          pc_n             = pc_plus2;
          instr_o          = {16'b0, mem_content_i[31:16]};
          instr_compress_o = 1'b1;
          update_state     = fetch_valid_i & id_valid_i;
        end
      end

      default: begin
        state_n      = ALIGNED32;
        update_state = 1'b1;
      end
    endcase

    // redirect overrides everything, nothing is delivered or popped
    if (branch_i) begin
      pc_n          = branch_addr_i;
      state_n       = branch_addr_i[1] ? BRANCH_MISALIGNED : ALIGNED32;
      update_state  = 1'b1;
      consume       = 1'b0;
      instr_valid_o = 1'b0;
    end
  end

  // head word used up exactly when its content moved on
  assign word_pop_o = consume & update_state;

endmodule

`default_nettype wire

// ==== source/fetch_top.sv ====
// fetch front end top: ram, arbiter, prefetch buffer and aligner
`timescale 1ns/1ps
`default_nettype none

module fetch_top
  import mem_pkg::*;
  import fetch_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       fetch_en_i,
  // program loader
  input  wire logic       load_we_i,
  input  wire mem_index_t load_index_i,
  input  wire mem_word_t  load_data_i,
  // decode stage
  input  wire logic       id_valid_i,
  input  wire logic       branch_i,
  input  wire pc_t        branch_addr_i,
  output mem_word_t       instr_o,
  output logic            instr_valid_o,
  output logic            instr_compress_o,
  output pc_t             pc_o
);

  // prefetch to arbiter
  logic       pf_req;
  mem_index_t pf_index;
  logic       pf_gnt;
  logic       pf_rvalid;
  // arbiter to ram
  logic       ram_en;
  logic       ram_we;
  mem_index_t ram_index;
  mem_word_t  ram_wdata;
  mem_word_t  ram_rdata;
  // prefetch to aligner
  logic       fetch_valid;
  mem_word_t  mem_content;
  logic       word_pop;

  instr_ram u_ram (
    .clk     (clk),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .index_i (ram_index),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

  ram_arbiter u_arb (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_we_i    (load_we_i),
    .load_index_i (load_index_i),
    .load_data_i  (load_data_i),
    .pf_req_i     (pf_req),
    .pf_index_i   (pf_index),
    .pf_gnt_o     (pf_gnt),
    .pf_rvalid_o  (pf_rvalid),
    .ram_en_o     (ram_en),
    .ram_we_o     (ram_we),
    .ram_index_o  (ram_index),
    .ram_wdata_o  (ram_wdata)
  );

  prefetch_buffer u_pf (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_en_i    (fetch_en_i),
    .gnt_i         (pf_gnt),
    .rvalid_i      (pf_rvalid),
    .rdata_i       (ram_rdata),
    .req_o         (pf_req),
    .index_o       (pf_index),
    .word_pop_i    (word_pop),
    .fetch_valid_o (fetch_valid),
    .mem_content_o (mem_content),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i)
  );

  instr_aligner u_align (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_valid_i    (fetch_valid),
    .mem_content_i    (mem_content),
    .word_pop_o       (word_pop),
    .id_valid_i       (id_valid_i),
    .instr_o          (instr_o),
    .instr_valid_o    (instr_valid_o),
    .instr_compress_o (instr_compress_o),
    .pc_o             (pc_o),
    .branch_i         (branch_i),
    .branch_addr_i    (branch_addr_i)
  );

endmodule

`default_nettype wire

// ==== tb/fetch_assertions.sv ====
// bound checks for fetch_top: reset state, ram port exclusivity, pc stepping
`timescale 1ns/1ps
`default_nettype none

module fetch_assertions
  import fetch_pkg::*;
(
  input wire logic clk,
  input wire logic rst_n,
  input wire logic ram_we_i,
  input wire logic pf_gnt_i,
  input wire logic instr_valid_i,
  input wire logic instr_compress_i,
  input wire logic id_valid_i,
  input wire logic branch_i,
  input wire pc_t  pc_i
);

  // read back by the testbench at the end of the run
  int unsigned fail_count = 0;

  logic accept;
  logic have_prev_q;
  logic prev_cmp_q;
  pc_t  prev_pc_q;

  assign accept = instr_valid_i & id_valid_i & ~branch_i;

  // last accepted instruction, forgotten on a redirect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      have_prev_q <= 1'b0;
      prev_cmp_q  <= 1'b0;
      prev_pc_q   <= '0;
    end else if (branch_i) begin
      have_prev_q <= 1'b0;
    end else if (accept) begin
      have_prev_q <= 1'b1;
      prev_cmp_q  <= instr_compress_i;
      prev_pc_q   <= pc_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // properties
  //////////////////////////////////////////////////////////////////////

  // queue is empty in reset, so nothing may look valid
  reset_quiet: assert property (@(posedge clk) !rst_n |-> !instr_valid_i)
    else begin
      $error("instr_valid_o high during reset");
      fail_count++;
    end

  // loader write and prefetch grant share one ram port
  port_exclusive: assert property (@(posedge clk) !(ram_we_i && pf_gnt_i))
    else begin
      $error("ram written and granted to prefetch in one cycle");
      fail_count++;
    end

  // sequential flow: +2 after a compressed instruction, +4 otherwise
  pc_step: assert property (@(posedge clk) disable iff (!rst_n)
    (accept && have_prev_q) |-> (pc_i == prev_pc_q + pc_t'(prev_cmp_q ? 2 : 4)))
    else begin
      $error("pc_o did not step by the previous instruction length");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== tb/fetch_tb.sv ====
// fetch front end testbench with program image, loader, stalls, branches and stream checks
`timescale 1ns/1ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_tb
  import mem_pkg::*;
  import fetch_pkg::*;
();

  localparam int RAM_W      = `FETCH_RAM_WORDS;
  localparam int RST_CYCLES = 8;
  // words rewritten by the loader while fetching runs elsewhere
  localparam int NEW_BASE   = 224;
  localparam int STALL_PCT  = 30;
  localparam int T1_N       = 8;
  localparam int T2_N       = 40;
  localparam int T3_N       = 40;
  localparam int T4_N       = 20;
  localparam int T5_N       = 30;
  localparam int TEST_LEN   = RST_CYCLES + RAM_W + T1_N + T2_N + 2 * T3_N + 4 * T4_N +
                              2 * T5_N + (RAM_W - NEW_BASE);
  localparam int LIMIT      = 4 * TEST_LEN;

  logic       clk;
  logic       rst_n;
  logic       fetch_en_i;
  logic       load_we_i;
  mem_index_t load_index_i;
  mem_word_t  load_data_i;
  logic       id_valid_i;
  logic       branch_i;
  pc_t        branch_addr_i;
  mem_word_t  instr_o;
  logic       instr_valid_o;
  logic       instr_compress_o;
  pc_t        pc_o;

  // program as halfwords, and the word image handed to the loader
  logic [15:0] img [2 * RAM_W];
  mem_word_t   ram_img [RAM_W];
  int          load_q [$];
  logic [31:0] rng;
  logic [13:0] uid;
  int          ptr;
  int          errors;
  int          checks;
  int          tests;
  int          cycles = 0;

  fetch_top uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_en_i       (fetch_en_i),
    .load_we_i        (load_we_i),
    .load_index_i     (load_index_i),
    .load_data_i      (load_data_i),
    .id_valid_i       (id_valid_i),
    .branch_i         (branch_i),
    .branch_addr_i    (branch_addr_i),
    .instr_o          (instr_o),
    .instr_valid_o    (instr_valid_o),
    .instr_compress_o (instr_compress_o),
    .pc_o             (pc_o)
  );

  bind fetch_top fetch_assertions u_chk (
    .clk              (clk),
    .rst_n            (rst_n),
    .ram_we_i         (ram_we),
    .pf_gnt_i         (pf_gnt),
    .instr_valid_i    (instr_valid_o),
    .instr_compress_i (instr_compress_o),
    .id_valid_i       (id_valid_i),
    .branch_i         (branch_i),
    .pc_i             (pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // filler built from every index bit for words the program never reaches
  function automatic mem_word_t fill_word(input int w);
    logic [7:0] b;
    b = 8'(w);
    return {b, ~b, b * 8'd7 + 8'd1, b ^ 8'h5a};
  endfunction

  // mode 0 mixed, 1 only 32-bit, 2 mixed with a 32-bit first instruction
  // every instruction carries a fresh uid in its low halfword
  task automatic gen_segment(input int first_hw, input int last_hw, input int mode);
    int hw;
    hw = first_hw;
    while (hw <= last_hw) begin
      rng = xorshift32(rng);
      if (hw < last_hw && (mode == 1 || (mode == 2 && hw == first_hw) || rng[4])) begin
        img[hw]     = {uid, 2'b11};
        img[hw + 1] = rng[31:16];
        hw += 2;
      end else begin
        img[hw] = {uid, (rng[1:0] == 2'b11) ? 2'b01 : rng[1:0]};
        hw += 1;
      end
      uid++;
    end
  endtask

  // one loader write per call while words are queued
  task automatic drive_loader();
    int w;
    if (load_q.size() != 0) begin
      w            = load_q.pop_front();
      load_we_i    = 1'b1;
      load_index_i = mem_index_t'(w);
      load_data_i  = ram_img[w];
    end else begin
      load_we_i = 1'b0;
    end
  endtask

  task automatic drain_loader();
    while (load_q.size() != 0) begin
      @(negedge clk);
      id_valid_i = 1'b0;
      drive_loader();
    end
  endtask

  // compare the accepted instruction with the image at ptr and step past it
  task automatic check_accept();
    logic      exp_cmp;
    mem_word_t exp_instr;
    exp_cmp   = (img[ptr][1:0] != 2'b11);
    exp_instr = exp_cmp ? {16'h0000, img[ptr]} : {img[ptr + 1], img[ptr]};
    checks++;
    assert (pc_o == pc_t'(2 * ptr)) else begin
      $display("[FAIL] %0d ns: pc_o %h, expected %h", $time, pc_o, 2 * ptr);
      errors++;
    end
    assert (instr_compress_o == exp_cmp) else begin
      $display("[FAIL] %0d ns: instr_compress_o %b at pc %h", $time, instr_compress_o, pc_o);
      errors++;
    end
    assert (instr_o == exp_instr) else begin
      $display("[FAIL] %0d ns: instr_o %h, expected %h", $time, instr_o, exp_instr);
      errors++;
    end
    ptr += exp_cmp ? 1 : 2;
  endtask

  // accept count instructions, outputs sampled 1 ns after the inputs change
  task automatic run_stream(input string name, input int count, input int stall_pct);
    int done;
    int errs0;
    done  = 0;
    errs0 = errors;
    while (done < count) begin
      @(negedge clk);
      branch_i = 1'b0;
      rng = xorshift32(rng);
      id_valid_i = (rng % 100) >= stall_pct;
      // queued loader writes take the ram port on about half the cycles
      if (rng[8]) begin
        drive_loader();
      end else begin
        load_we_i = 1'b0;
      end
      #1;
      if (instr_valid_o && id_valid_i) begin
        check_accept();
        done++;
      end
    end
    tests++;
    $display("test %s: %0d instructions, %0d errors", name, count, errors - errs0);
  endtask

  // one-cycle redirect that restarts the model at the target halfword
  task automatic branch_to(input int hw);
    drain_loader();
    @(negedge clk);
    load_we_i     = 1'b0;
    id_valid_i    = 1'b0;
    branch_i      = 1'b1;
    branch_addr_i = pc_t'(2 * hw);
    ptr           = hw;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n         = 1'b0;
    fetch_en_i    = 1'b0;
    load_we_i     = 1'b0;
    load_index_i  = '0;
    load_data_i   = '0;
    id_valid_i    = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    rng           = 32'h0c00fec6;
    uid           = '0;
    ptr           = 0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    for (int i = 0; i < 2 * RAM_W; i++) begin
      img[i] = '0;
    end
    // aligned run, long mixed run, branch targets at halfwords 200 and 261
    gen_segment(0, 15, 1);
    gen_segment(16, 199, 0);
    gen_segment(200, 260, 0);
    gen_segment(261, 319, 2);
    gen_segment(320, 447, 0);
    for (int w = 0; w < RAM_W; w++) begin
      ram_img[w] = (w >= NEW_BASE) ? fill_word(w) : {img[2 * w + 1], img[2 * w]};
      load_q.push_back(w);
    end
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    drain_loader();
    @(negedge clk);
    load_we_i  = 1'b0;
    fetch_en_i = 1'b1;
    run_stream("aligned32", T1_N, 0);
    run_stream("mixed", T2_N, 0);
    // same stretch again under decode stalls
    branch_to(16);
    run_stream("backpressure", T3_N, STALL_PCT);
    branch_to(200);
    run_stream("branch_word_target", T4_N, STALL_PCT);
    branch_to(261);
    run_stream("branch_half_target", T4_N, STALL_PCT);
    // new code goes into the top words while the stream runs lower down
    branch_to(320);
    gen_segment(2 * NEW_BASE, 2 * RAM_W - 1, 0);
    for (int w = NEW_BASE; w < RAM_W; w++) begin
      ram_img[w] = {img[2 * w + 1], img[2 * w]};
      load_q.push_back(w);
    end
    run_stream("load_during_fetch", T5_N, 0);
    branch_to(2 * NEW_BASE);
    run_stream("branch_new_code", T5_N, STALL_PCT);
    @(negedge clk);
    $display("tests %0d, checks %0d, stream errors %0d, assertion errors %0d",
             tests, checks, errors, uut.u_chk.fail_count);
    if (errors == 0 && uut.u_chk.fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+source
source/mem_pkg.sv
source/fetch_pkg.sv
source/instr_ram.sv
source/ram_arbiter.sv
source/prefetch_buffer.sv
source/instr_aligner.sv
source/fetch_top.sv
tb/fetch_assertions.sv
tb/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the fetch front end testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fetch_tb -f build.f -o Vfetch_tb \
  && ./obj_dir/Vfetch_tb | tee /dev/stderr | grep "Simulation PASSED" > /dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: build or simulation failed"; exit 1; }
